//--- compile.f
+incdir+include
verilog/rv_core_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/rv_core_top.sv
tests/rv_core_tb.sv

//--- include/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data and address width.
`define RV_XLEN 32

// rv32e has 16 integer registers.
`define RV_REG_AW 4
`define RV_NUM_REGS 16

// data memory size in 32-bit words.
`define RV_DMEM_WORDS 256

`endif

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ns --top-module rv_core_tb -f compile.f -o rv_core_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "run failed"; exit 1; }
! grep -q "Testbench failed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tests/rv_core_golden.mem
// words 0 to 23 are the program image at pc 0, four per line; word 24 is the record count.
// each record line is pc, rd, data, flags {reg_wen, ecall, mret, fencei}; rd and data are 0 without a write.
123450b7 67808113 00001197 00310233 // 00: lui x1, auipc chain, add x4 = x2 + x3
402202b3 00528013 00500333 04000393 // 10: sub x5, addi x0, add x6 = x0 + x5, addi x7
0043a023 0023a223 0003a403 0043a483 // 20: sw x4 0(x7), sw x2 4(x7), lw x8, lw x9
00440463 7ff00513 00940463 008005ef // 30: beq taken to 38, wrong path, beq not taken, jal x11
00200513 00d58667 00300513 00b606b3 // 40: wrong path, jalr x12 13(x11), wrong path, add x13
0000100f 00000073 30200073 ff868713 // 50: fence.i, ecall, mret, addi x14 = x13 - 8
00000015
00000000 1 12345000 8
00000004 2 12345678 8
00000008 3 00001008 8
0000000c 4 12346680 8
00000010 5 00001008 8
00000014 0 00000000 0
00000018 6 00001008 8
0000001c 7 00000040 8
00000020 0 00000000 0
00000024 0 00000000 0
00000028 8 12346680 8
0000002c 9 12345678 8
00000030 0 00000000 0
00000038 0 00000000 0
0000003c b 00000040 8
00000044 c 00000048 8
0000004c d 00000088 8
00000050 0 00000000 1
00000054 0 00000000 4
00000058 0 00000000 2
0000005c e 00000080 8

//--- tests/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_tb;

	import rv_core_pkg::*;

	localparam int prog_words     = 24;
	localparam int max_records    = 21;
	localparam int golden_words   = prog_words + 1 + 4 * max_records;
	localparam int timeout_cycles = prog_words * 20 + 200;

	logic                clock;
	logic                rst;
	logic                fetch_valid;
	fetch_t              fetch;
	logic                fetch_ready;
	logic                redirect;
	logic [`RV_XLEN-1:0] redirect_pc;
	logic                retire_valid;
	retire_t             retire;

	logic [31:0] golden [golden_words];
	logic [31:0] fetch_pc;
	logic [7:0]  lfsr;
	logic        transfer;
	int          gap;
	int          num_expected;
	int          num_seen;
	int          num_redirects;
	int          exp_redirects;
	int          errors;

	rv_core_top uut (
		.clock        (clock),
		.rst          (rst),
		.fetch_valid  (fetch_valid),
		.fetch        (fetch),
		.fetch_ready  (fetch_ready),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// x^8 + x^6 + x^5 + x^4 + 1.
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic feedback;
		feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], feedback};
	endfunction

	task automatic draw_gap(output int n);
		n = 0;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_next(lfsr);
			n    = n * 2 + (lfsr[0] ? 1 : 0);  // one step per bit.
		end
	endtask

	function automatic string test_name(input logic [31:0] pc);
		if (pc < 32'h20) begin
			return "arith_hazard";
		end else if (pc < 32'h30) begin
			return "memory";
		end else if (pc < 32'h50) begin
			return "control_flow";
		end
		return "system";
	endfunction

	task automatic report_mismatch(input string name, input string field,
	                               input logic [31:0] expected, input logic [31:0] actual);
		$display("[ERROR] %s record %0d %s: expected %08h, actual %08h",
		         name, num_seen, field, expected, actual);
		errors++;
	endtask

	// a jump leaves the fall-through pc sequence of the golden stream.
	task automatic count_expected_redirects();
		int base;
		exp_redirects = 0;
		for (int i = 0; i + 1 < num_expected; i++) begin
			base = prog_words + 1 + 4 * i;
			if (golden[base+4] != golden[base] + 32'd4) begin
				exp_redirects++;
			end
		end
	endtask

	// the jump sits in execute, so the record after it must start at the target.
	task automatic check_redirect();
		int next_base;
		next_base = prog_words + 1 + 4 * (num_seen + 1);
		num_redirects++;
		if (num_seen + 1 >= num_expected) begin
			$display("redirect to %08h with no expected record left to follow it",
			         redirect_pc);
			errors++;
		end else if (redirect_pc !== golden[next_base]) begin
			report_mismatch(test_name(golden[next_base-4]), "redirect_pc",
			                golden[next_base], redirect_pc);
		end
	endtask

	task automatic check_retire();
		int         base;
		string      name;
		logic [3:0] exp_flags;
		logic [3:0] act_flags;
		base = prog_words + 1 + 4 * num_seen;
		if (num_seen >= num_expected) begin
			$display("extra retire record at pc %08h beyond the expected stream", retire.pc);
			errors++;
		end else begin
			name      = test_name(golden[base]);
			exp_flags = golden[base+3][3:0];
			act_flags = {retire.reg_wen, retire.ecall, retire.mret, retire.fencei};
			if (retire.pc !== golden[base]) begin
				report_mismatch(name, "pc", golden[base], retire.pc);
			end
			if (act_flags !== exp_flags) begin
				report_mismatch(name, "flags", {28'd0, exp_flags}, {28'd0, act_flags});
			end
			// rd and data only carry meaning for a register write.
			if (exp_flags[3]) begin
				if (retire.rd !== golden[base+1][3:0]) begin
					report_mismatch(name, "rd", {28'd0, golden[base+1][3:0]}, {28'd0, retire.rd});
				end
				if (retire.data !== golden[base+2]) begin
					report_mismatch(name, "data", golden[base+2], retire.data);
				end
			end
		end
		num_seen++;
	endtask

	// fetch side, run on every falling edge.
	task automatic drive_fetch();
		if (transfer) begin
			fetch_pc = fetch_pc + 32'd4;
			draw_gap(gap);
		end
		if (redirect) begin
			fetch_pc = redirect_pc;  // drop the current offer.
		end
		if (gap > 0) begin
			gap--;
			fetch_valid = 1'b0;
		end else if (fetch_pc < prog_words * 4) begin
			fetch_valid = 1'b1;
			fetch.inst  = golden[fetch_pc / 4];
			fetch.pc    = fetch_pc;
		end else begin
			fetch_valid = 1'b0;
		end
		transfer = fetch_valid & fetch_ready;  // ready is settled since the rising edge.
	endtask

	initial begin
		rst           = 1'b1;
		fetch_valid   = 1'b0;
		fetch         = '0;
		fetch_pc      = '0;
		lfsr          = 8'd72;
		transfer      = 1'b0;
		gap           = 0;
		num_seen      = 0;
		num_redirects = 0;
		exp_redirects = 0;
		errors        = 0;
		$readmemh("tests/rv_core_golden.mem", golden);
		num_expected = golden[prog_words];
		repeat (10) @(negedge clock);
		rst = 1'b0;

		if (num_expected < 1 || num_expected > max_records) begin
			$display("golden file holds an invalid record count of %0d", num_expected);
			errors++;
		end else begin
			count_expected_redirects();
			while (num_seen < num_expected) begin
				@(negedge clock);
				if (retire_valid) begin
					check_retire();
				end
				if (redirect) begin
					check_redirect();
				end
				drive_fetch();
			end
		end

		fetch_valid = 1'b0;
		repeat (8) begin
			@(negedge clock);
			if (retire_valid) begin
				check_retire();
			end
		end

		if (num_redirects != exp_redirects) begin
			$display("saw %0d redirects where the expected stream implies %0d",
			         num_redirects, exp_redirects);
			errors++;
		end

		$display("errors: %0d, records retired: %0d, records expected: %0d",
		         errors, num_seen, num_expected);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles with %0d of %0d records retired",
		         timeout_cycles, num_seen, num_expected);
		$display("errors: %0d, records retired: %0d, records expected: %0d",
		         errors, num_seen, num_expected);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module decode_stage (
	input  wire logic                  clock,
	input  wire logic                  rst,

	input  wire logic                  fetch_valid,
	input  wire rv_core_pkg::fetch_t   fetch,
	output logic                       fetch_ready,

	output logic      [`RV_REG_AW-1:0] rs1,
	output logic      [`RV_REG_AW-1:0] rs2,
	input  wire logic [`RV_XLEN-1:0]   rs1_val,
	input  wire logic [`RV_XLEN-1:0]   rs2_val,

	input  wire logic [`RV_REG_AW-1:0] exe_rd,
	input  wire logic                  exe_reg_wen,
	input  wire logic [`RV_REG_AW-1:0] mem_rd,
	input  wire logic                  mem_reg_wen,
	input  wire logic                  redirect,

	output logic                       dec_valid,
	output rv_core_pkg::decoded_t      dec_bundle
);

	import rv_core_pkg::*;

	logic [31:0]           inst_q;
	logic [`RV_XLEN-1:0]   pc_q;
	logic                  full_q;
	logic                  started_q;
	logic                  accept;

	logic [6:0]            opcode;
	logic [num_ops-1:0]    op;
	logic [num_fmts-1:0]   fmt;
	logic [`RV_REG_AW-1:0] rd;
	logic [`RV_XLEN-1:0]   imm;
	logic                  writes_rd;
	logic                  need_rs2;
	logic                  exe_hit;
	logic                  mem_hit;

	// a flush frees the slot for the redirect target.
	assign fetch_ready = started_q & (~full_q | dec_valid | redirect);
	assign accept      = fetch_valid & fetch_ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			full_q    <= 1'b0;
			started_q <= 1'b0;
		end else begin
			started_q <= 1'b1;
			if (accept) begin
				full_q <= 1'b1;
			end else if (dec_valid | redirect) begin
				full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			inst_q <= fetch.inst;
			pc_q   <= fetch.pc;
		end
	end

	assign opcode = inst_q[6:0];
	assign rs1    = inst_q[18:15];
	assign rs2    = inst_q[23:20];
	assign rd     = inst_q[10:7];

	assign op[op_lui]    = (opcode == 7'b0110111);
	assign op[op_auipc]  = (opcode == 7'b0010111);
	assign op[op_jal]    = (opcode == 7'b1101111);
	assign op[op_jalr]   = (opcode == 7'b1100111);
	assign op[op_beq]    = (opcode == 7'b1100011);
	assign op[op_lw]     = (opcode == 7'b0000011);
	assign op[op_sw]     = (opcode == 7'b0100011);
	assign op[op_addi]   = (opcode == 7'b0010011);
	assign op[op_add]    = (opcode == 7'b0110011);
	assign op[op_system] = (opcode == 7'b1110011);

	assign fmt[fmt_r] = op[op_add];
	assign fmt[fmt_i] = op[op_jalr] | op[op_lw] | op[op_addi] | op[op_system];
	assign fmt[fmt_s] = op[op_sw];
	assign fmt[fmt_b] = op[op_beq];
	assign fmt[fmt_u] = op[op_lui] | op[op_auipc];
	assign fmt[fmt_j] = op[op_jal];

	always_comb begin
		if (fmt[fmt_i]) begin
			imm = {{20{inst_q[31]}}, inst_q[31:20]};
		end else if (fmt[fmt_s]) begin
			imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
		end else if (fmt[fmt_b]) begin
			imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
		end else if (fmt[fmt_u]) begin
			imm = {inst_q[31:12], 12'b0};
		end else if (fmt[fmt_j]) begin
			imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
		end else begin
			imm = '0;
		end
	end

	// writes to x0 are dropped here.
	assign writes_rd = ((fmt[fmt_i] & ~op[op_system]) | fmt[fmt_u] | fmt[fmt_j] | fmt[fmt_r])
	                   & (rd != '0);

	// raw check against what is still in execute and mem.
	assign need_rs2 = op[op_beq] | op[op_sw] | op[op_add];
	assign exe_hit  = exe_reg_wen & (exe_rd != '0) &
	                  ((exe_rd == rs1) | (need_rs2 & (exe_rd == rs2)));
	assign mem_hit  = mem_reg_wen & (mem_rd != '0) &
	                  ((mem_rd == rs1) | (need_rs2 & (mem_rd == rs2)));

	assign dec_valid = full_q & ~exe_hit & ~mem_hit & ~redirect;

	always_comb begin
		dec_bundle.pc          = pc_q;
		dec_bundle.opcode_type = op;
		dec_bundle.funct3      = inst_q[14:12];
		dec_bundle.funct7      = inst_q[31:25];
		dec_bundle.rd          = rd;
		dec_bundle.rs1_val     = rs1_val;
		dec_bundle.rs2_val     = rs2_val;
		dec_bundle.imm         = imm;
		dec_bundle.reg_wen     = writes_rd;
		dec_bundle.ecall       = (inst_q == 32'h00000073);
		dec_bundle.mret        = (inst_q == 32'h30200073);
		dec_bundle.fencei      = (opcode == 7'b0001111);
	end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module execute_stage (
	input  wire logic                   clock,
	input  wire logic                   rst,

	input  wire logic                   dec_valid,
	input  wire rv_core_pkg::decoded_t  dec_bundle,

	output logic                        exe_valid,
	output rv_core_pkg::exec_t          exe_bundle,
	output logic      [`RV_REG_AW-1:0]  exe_rd,
	output logic                        exe_reg_wen,

	output logic                        redirect,
	output logic      [`RV_XLEN-1:0]    redirect_pc
);

	import rv_core_pkg::*;

	logic [num_ops-1:0]  op;
	logic [`RV_XLEN-1:0] rs1_imm;
	logic [`RV_XLEN-1:0] pc_imm;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] result;
	logic [`RV_XLEN-1:0] target;
	logic                is_sub;
	logic                take_jump;

	assign op       = dec_bundle.opcode_type;
	assign rs1_imm  = dec_bundle.rs1_val + dec_bundle.imm;  // addi, lw, sw, jalr.
	assign pc_imm   = dec_bundle.pc + dec_bundle.imm;
	assign pc_plus4 = dec_bundle.pc + `RV_XLEN'd4;
	assign is_sub   = dec_bundle.funct7[5] & (dec_bundle.funct3 == 3'b000);

	always_comb begin
		if (op[op_lui]) begin
			result = dec_bundle.imm;
		end else if (op[op_auipc]) begin
			result = pc_imm;
		end else if (op[op_jal] | op[op_jalr]) begin
			result = pc_plus4;  // link value.
		end else if (op[op_add]) begin
			result = is_sub ? dec_bundle.rs1_val - dec_bundle.rs2_val
			                : dec_bundle.rs1_val + dec_bundle.rs2_val;
		end else begin
			result = rs1_imm;
		end
	end

	assign take_jump = dec_valid & (op[op_jal] | op[op_jalr] |
	                   (op[op_beq] & (dec_bundle.rs1_val == dec_bundle.rs2_val)));
	assign target    = op[op_jalr] ? {rs1_imm[`RV_XLEN-1:1], 1'b0} : pc_imm;

	always_ff @(posedge clock) begin
		if (rst) begin
			exe_valid <= 1'b0;
			redirect  <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
			redirect  <= take_jump;
		end
	end

	always_ff @(posedge clock) begin
		redirect_pc           <= target;
		exe_bundle.pc         <= dec_bundle.pc;
		exe_bundle.rd         <= dec_bundle.rd;
		exe_bundle.reg_wen    <= dec_bundle.reg_wen;
		exe_bundle.is_load    <= op[op_lw];
		exe_bundle.is_store   <= op[op_sw];
		exe_bundle.result     <= result;
		exe_bundle.store_data <= dec_bundle.rs2_val;
		exe_bundle.ecall      <= dec_bundle.ecall;
		exe_bundle.mret       <= dec_bundle.mret;
		exe_bundle.fencei     <= dec_bundle.fencei;
	end

	assign exe_rd      = exe_bundle.rd;
	assign exe_reg_wen = exe_valid & exe_bundle.reg_wen;

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module mem_stage (
	input  wire logic                  clock,
	input  wire logic                  rst,

	input  wire logic                  exe_valid,
	input  wire rv_core_pkg::exec_t    exe_bundle,

	output logic      [`RV_REG_AW-1:0] mem_rd,
	output logic                       mem_reg_wen,

	output logic                       wb_en,
	output logic      [`RV_REG_AW-1:0] wb_rd,
	output logic      [`RV_XLEN-1:0]   wb_data,

	output logic                       retire_valid,
	output rv_core_pkg::retire_t       retire
);

	import rv_core_pkg::*;

	localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

	logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
	logic                valid_q;
	exec_t               rec_q;
	logic [dmem_aw-1:0]  word_addr;
	logic [`RV_XLEN-1:0] load_data;

	initial begin
		for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
			dmem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= exe_valid;
		end
	end

	always_ff @(posedge clock) begin
		rec_q <= exe_bundle;
	end

	assign word_addr = rec_q.result[dmem_aw+1:2];  // byte offset ignored.
	assign load_data = dmem[word_addr];

	always_ff @(posedge clock) begin
		if (valid_q & rec_q.is_store) begin
			dmem[word_addr] <= rec_q.store_data;
		end
	end

	assign wb_en   = valid_q & rec_q.reg_wen;
	assign wb_rd   = rec_q.rd;
	assign wb_data = rec_q.is_load ? load_data : rec_q.result;

	assign mem_rd      = rec_q.rd;
	assign mem_reg_wen = wb_en;

	assign retire_valid = valid_q;

	always_comb begin
		retire.pc      = rec_q.pc;
		retire.rd      = rec_q.rd;
		retire.reg_wen = rec_q.reg_wen;
		retire.data    = wb_data;
		retire.ecall   = rec_q.ecall;
		retire.mret    = rec_q.mret;
		retire.fencei  = rec_q.fencei;
	end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module reg_file (
	input  wire logic                  clock,
	input  wire logic                  rst,
	input  wire logic [`RV_REG_AW-1:0] rs1,
	input  wire logic [`RV_REG_AW-1:0] rs2,
	output logic      [`RV_XLEN-1:0]   rs1_val,
	output logic      [`RV_XLEN-1:0]   rs2_val,
	input  wire logic                  wb_en,
	input  wire logic [`RV_REG_AW-1:0] wb_rd,
	input  wire logic [`RV_XLEN-1:0]   wb_data
);

	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (wb_rd != '0)) begin
			regs[wb_rd] <= wb_data;  // x0 stays zero.
		end
	end

	// same-cycle writeback is forwarded to the readers.
	assign rs1_val = (rs1 == '0) ? '0 :
	                 (wb_en && (wb_rd == rs1)) ? wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
	                 (wb_en && (wb_rd == rs2)) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

	localparam int num_ops  = 10;
	localparam int num_fmts = 6;

	// bit positions in the one-hot opcode type.
	typedef enum int unsigned {
		op_lui = 0,
		op_auipc,
		op_jal,
		op_jalr,
		op_beq,
		op_lw,
		op_sw,
		op_addi,
		op_add,
		op_system
	} op_idx;

	typedef enum int unsigned {
		fmt_r = 0,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} fmt_idx;

	typedef struct packed {
		logic [31:0]         inst;
		logic [`RV_XLEN-1:0] pc;
	} fetch_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0]   pc;
		logic [num_ops-1:0]    opcode_type;
		logic [2:0]            funct3;
		logic [6:0]            funct7;
		logic [`RV_REG_AW-1:0] rd;
		logic [`RV_XLEN-1:0]   rs1_val;
		logic [`RV_XLEN-1:0]   rs2_val;
		logic [`RV_XLEN-1:0]   imm;
		logic                  reg_wen;
		logic                  ecall;
		logic                  mret;
		logic                  fencei;
	} decoded_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0]   pc;
		logic [`RV_REG_AW-1:0] rd;
		logic                  reg_wen;
		logic                  is_load;
		logic                  is_store;
		logic [`RV_XLEN-1:0]   result;  // alu result or memory address.
		logic [`RV_XLEN-1:0]   store_data;
		logic                  ecall;
		logic                  mret;
		logic                  fencei;
	} exec_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0]   pc;
		logic [`RV_REG_AW-1:0] rd;
		logic                  reg_wen;
		logic [`RV_XLEN-1:0]   data;
		logic                  ecall;
		logic                  mret;
		logic                  fencei;
	} retire_t;

endpackage

`default_nettype wire

//--- verilog/rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_top (
	input  wire logic                clock,
	input  wire logic                rst,

	input  wire logic                fetch_valid,
	input  wire rv_core_pkg::fetch_t fetch,
	output logic                     fetch_ready,

	output logic                     redirect,
	output logic [`RV_XLEN-1:0]      redirect_pc,

	output logic                     retire_valid,
	output rv_core_pkg::retire_t     retire
);

	import rv_core_pkg::*;

	logic [`RV_REG_AW-1:0] rs1;
	logic [`RV_REG_AW-1:0] rs2;
	logic [`RV_XLEN-1:0]   rs1_val;
	logic [`RV_XLEN-1:0]   rs2_val;

	logic                  dec_valid;
	decoded_t              dec_bundle;
	logic                  exe_valid;
	exec_t                 exe_bundle;

	logic [`RV_REG_AW-1:0] exe_rd;
	logic                  exe_reg_wen;
	logic [`RV_REG_AW-1:0] mem_rd;
	logic                  mem_reg_wen;

	logic                  wb_en;
	logic [`RV_REG_AW-1:0] wb_rd;
	logic [`RV_XLEN-1:0]   wb_data;

	reg_file u_reg_file (
		.clock   (clock),
		.rst     (rst),
		.rs1     (rs1),
		.rs2     (rs2),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.wb_en   (wb_en),
		.wb_rd   (wb_rd),
		.wb_data (wb_data)
	);

	decode_stage u_decode (
		.clock       (clock),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.fetch_ready (fetch_ready),
		.rs1         (rs1),
		.rs2         (rs2),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.exe_rd      (exe_rd),
		.exe_reg_wen (exe_reg_wen),
		.mem_rd      (mem_rd),
		.mem_reg_wen (mem_reg_wen),
		.redirect    (redirect),
		.dec_valid   (dec_valid),
		.dec_bundle  (dec_bundle)
	);

	execute_stage u_execute (
		.clock       (clock),
		.rst         (rst),
		.dec_valid   (dec_valid),
		.dec_bundle  (dec_bundle),
		.exe_valid   (exe_valid),
		.exe_bundle  (exe_bundle),
		.exe_rd      (exe_rd),
		.exe_reg_wen (exe_reg_wen),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	mem_stage u_mem (
		.clock        (clock),
		.rst          (rst),
		.exe_valid    (exe_valid),
		.exe_bundle   (exe_bundle),
		.mem_rd       (mem_rd),
		.mem_reg_wen  (mem_reg_wen),
		.wb_en        (wb_en),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

endmodule

`default_nettype wire
